// ==== hex_display.sv ====
`timescale 1ns/1ns

module hex_display #(
  parameter int unsigned REFRESH_TICKS = 25_000_000
) (
  input  logic                     CLK_50M,
  input  logic                     rst_n,
  input  organ_pkg::sample_count_t sample_count,
  output organ_pkg::seg_t          hex0,
  output organ_pkg::seg_t          hex1,
  output organ_pkg::seg_t          hex2,
  output organ_pkg::seg_t          hex3,
  output organ_pkg::seg_t          hex4,
  output organ_pkg::seg_t          hex5
);
  import organ_pkg::*;

  localparam int CNT_W = $clog2(REFRESH_TICKS + 1);
  localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(REFRESH_TICKS - 1);

  logic [CNT_W-1:0] refresh_cnt;
  logic             refresh_tick;
  sample_count_t    shown;      // Held between refreshes
  logic [23:0]      digit_val;  // Six nibbles, top two always zero
  seg_t             segs [6];

  // ====================================================================
  // Refresh tick and display latch
  // ====================================================================
  assign refresh_tick = (refresh_cnt == LAST_TICK);

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      refresh_cnt <= '0;
    end
    else
    begin
      refresh_cnt <= refresh_tick ? '0 : refresh_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shown <= '0;
    end
    else if (refresh_tick)
    begin
      shown <= sample_count;
    end
  end

  // ====================================================================
  // Hex decoders
  // ====================================================================
  assign digit_val = {8'h00, shown};

  for (genvar i = 0; i < 6; i++)
  begin : g_digit
    assign segs[i] = HEX_SEGMENTS[digit_val[4*i +: 4]];
  end

  assign hex0 = segs[0];  // Low nibble
  assign hex1 = segs[1];
  assign hex2 = segs[2];
  assign hex3 = segs[3];
  assign hex4 = segs[4];  // Always 0
  assign hex5 = segs[5];

endmodule

// ==== organ_asserts.sv ====
`timescale 1ns/1ns

module organ_asserts #(
  parameter bit STEP_CHECKS   = 1'b1,
  parameter bit SAMPLE_CHECKS = 1'b1
) (
  input logic               CLK_50M,
  input logic               rst_n,
  input logic               up_step,
  input logic               down_step,
  input organ_pkg::sample_t audio_sample
);
  import organ_pkg::*;

  // ====================================================================
  // Step pulses
  // ====================================================================
  if (STEP_CHECKS)
  begin : g_steps
    a_up_single: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      up_step |=> !up_step)
      else $error("up_step high for two cycles in a row");

    a_down_single: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      down_step |=> !down_step)
      else $error("down_step high for two cycles in a row");

    a_no_both: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      !(up_step && down_step))
      else $error("up_step and down_step high together");
  end

  // Sample only ever takes the two square-wave levels
  if (SAMPLE_CHECKS)
  begin : g_sample
    a_sample_levels: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      (audio_sample == SAMPLE_LOW) || (audio_sample == SAMPLE_HIGH))
      else $error("audio_sample has level %h", audio_sample);
  end

endmodule

bind speed_keys organ_asserts #(
  .SAMPLE_CHECKS (1'b0)
) keys_asserts_i (
  .CLK_50M      (CLK_50M),
  .rst_n        (rst_n),
  .up_step      (up_step),
  .down_step    (down_step),
  .audio_sample (organ_pkg::SAMPLE_LOW)  // No tone here
);

bind tone_generator organ_asserts #(
  .STEP_CHECKS (1'b0)
) tone_asserts_i (
  .CLK_50M      (CLK_50M),
  .rst_n        (rst_n),
  .up_step      (1'b0),
  .down_step    (1'b0),
  .audio_sample (audio_sample)
);

// ==== organ_pkg.sv ====
package organ_pkg;

  // ====================================================================
  // Types
  // ====================================================================
  typedef logic [2:0]         note_code_t;    // Note select from switches
  typedef logic signed [7:0]  sample_t;       // Signed audio sample
  typedef logic [15:0]        half_period_t;  // Cycles per half wave
  typedef logic signed [15:0] speed_t;        // Signed speed offset
  typedef logic [15:0]        sample_count_t; // Scope sampling count, wraps
  typedef logic [6:0]         seg_t;          // Active low, g..a

  // ====================================================================
  // Note table
  // ====================================================================
  // Half periods at 50 MHz, entries 011 and 100 swapped as on the board
  localparam half_period_t NOTE_HALF_PERIOD [8] = '{
    16'd47801,  // 000  523 Hz
    16'd42589,  // 001  587 Hz
    16'd37936,  // 010  659 Hz
    16'd31928,  // 011  783 Hz
    16'd35816,  // 100  698 Hz
    16'd28409,  // 101  880 Hz
    16'd25329,  // 110  987 Hz
    16'd23900   // 111  1046 Hz
  };

  localparam sample_t SAMPLE_LOW  = 8'sh80; // Low level and mute
  localparam sample_t SAMPLE_HIGH = 8'sh7F;

  // Speed control
  localparam speed_t        SPEED_STEP           = 16'sd100;
  localparam sample_count_t DEFAULT_SAMPLE_COUNT = 16'd12499; // 0x30D3

  // Hex glyphs 0 to F
  localparam seg_t HEX_SEGMENTS [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30,
    7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03,
    7'h46, 7'h21, 7'h06, 7'h0E
  };

endpackage

// ==== organ_top.sv ====
`timescale 1ns/1ns

module organ_top #(
  parameter int unsigned REPEAT_TICKS  = 5_000_000,   // 10 steps per second
  parameter int unsigned REFRESH_TICKS = 25_000_000   // 2 Hz display
) (
  input  logic               CLK_50M,
  input  logic               rst_n,
  input  logic [3:0]         sw,   // 3:1 note, 0 enable
  input  logic [2:0]         key,  // Active low
  output organ_pkg::sample_t audio_sample,
  output organ_pkg::seg_t    hex0,
  output organ_pkg::seg_t    hex1,
  output organ_pkg::seg_t    hex2,
  output organ_pkg::seg_t    hex3,
  output organ_pkg::seg_t    hex4,
  output organ_pkg::seg_t    hex5
);
  import organ_pkg::*;

  logic          up_step;
  logic          down_step;
  logic          clear_speed;
  sample_count_t sample_count;

  // ====================================================================
  // Tone path
  // ====================================================================
  tone_generator tone_generator_i (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .note         (sw[3:1]),
    .enable       (sw[0]),
    .audio_sample (audio_sample)
  );

  // ====================================================================
  // Speed keys to sampling count to display
  // ====================================================================
  speed_keys #(
    .REPEAT_TICKS (REPEAT_TICKS)
  ) speed_keys_i (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .key         (key),
    .up_step     (up_step),
    .down_step   (down_step),
    .clear_speed (clear_speed)
  );

  sample_rate_control sample_rate_control_i (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .up_step      (up_step),
    .down_step    (down_step),
    .clear_speed  (clear_speed),
    .sample_count (sample_count)
  );

  hex_display #(
    .REFRESH_TICKS (REFRESH_TICKS)
  ) hex_display_i (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .sample_count (sample_count),
    .hex0 (hex0),
    .hex1 (hex1),
    .hex2 (hex2),
    .hex3 (hex3),
    .hex4 (hex4),
    .hex5 (hex5)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the organ testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_organ -f vlog.f \
  --Mdir obj_dir -o tb_organ_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_organ_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Regression passed$" sim.log; then
  exit 0
fi
exit 1

// ==== sample_rate_control.sv ====
`timescale 1ns/1ns

module sample_rate_control (
  input  logic                     CLK_50M,
  input  logic                     rst_n,
  input  logic                     up_step,
  input  logic                     down_step,
  input  logic                     clear_speed,
  output organ_pkg::sample_count_t sample_count
);
  import organ_pkg::*;

  speed_t speed;

  // ====================================================================
  // Speed register
  // ====================================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      speed <= '0;
    end
    else if (clear_speed)
    begin
      speed <= '0;  // Clear wins over any step
    end
    else if (up_step)
    begin
      speed <= speed + SPEED_STEP;
    end
    else if (down_step)
    begin
      speed <= speed - SPEED_STEP;
    end
  end

  // Sampling count, modulo 2^16
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sample_count <= DEFAULT_SAMPLE_COUNT;
    end
    else
    begin
      sample_count <= DEFAULT_SAMPLE_COUNT + sample_count_t'(speed);
    end
  end

endmodule

// ==== speed_keys.sv ====
`timescale 1ns/1ns

module speed_keys #(
  parameter int unsigned REPEAT_TICKS = 5_000_000
) (
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  logic [2:0] key,       // 0 up, 1 down, 2 clear, active low
  output logic       up_step,
  output logic       down_step,
  output logic       clear_speed
);

  localparam int CNT_W = $clog2(REPEAT_TICKS + 1);
  localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(REPEAT_TICKS - 1);

  logic [2:0]       key_meta;
  logic [2:0]       key_sync;
  logic [CNT_W-1:0] tick_cnt;
  logic             tick;
  logic             up_held;
  logic             down_held;

  // ====================================================================
  // Key synchronizers
  // ====================================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      key_meta <= 3'b111;  // Released
      key_sync <= 3'b111;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  assign up_held     = ~key_sync[0];
  assign down_held   = ~key_sync[1];
  assign clear_speed = ~key_sync[2];  // Level, no repeat limit

  // ====================================================================
  // Repeat tick and step pulses
  // ====================================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tick_cnt <= '0;
      tick     <= 1'b0;
    end
    else
    begin
      tick     <= (tick_cnt == LAST_TICK);
      tick_cnt <= (tick_cnt == LAST_TICK) ? '0 : tick_cnt + 1'b1;
    end
  end

  // Both keys held cancel out
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      up_step   <= 1'b0;
      down_step <= 1'b0;
    end
    else
    begin
      up_step   <= tick & up_held & ~down_held;
      down_step <= tick & down_held & ~up_held;
    end
  end

endmodule

// ==== tb_organ.sv ====
`timescale 1ns/1ns

module tb_organ;
  import organ_pkg::*;

  localparam int unsigned REPEAT_TICKS  = 200;
  localparam int unsigned REFRESH_TICKS = 10;
  localparam int unsigned STEP_WAIT     = 300;     // Step plus display follow
  localparam int unsigned TONE_WAIT     = 50_000;  // Above any half period
  localparam int unsigned LONGEST_HALF  = 47_801;
  localparam int unsigned SETTLE        = 2 * REFRESH_TICKS + 4;
  localparam logic [15:0] EXP_DEFAULT   = 16'h30D3;
  localparam int          EXP_STEP      = 100;

  logic       CLK_50M;
  logic       rst_n;
  logic [3:0] sw;   // 3:1 note, 0 enable
  logic [2:0] key;  // 0 up, 1 down, 2 clear, active low
  sample_t    audio_sample;
  seg_t       hex0;
  seg_t       hex1;
  seg_t       hex2;
  seg_t       hex3;
  seg_t       hex4;
  seg_t       hex5;

  int     error_count;
  int     test_count;
  integer seed;

  organ_top #(
    .REPEAT_TICKS  (REPEAT_TICKS),
    .REFRESH_TICKS (REFRESH_TICKS)
  ) dut_i (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .sw           (sw),
    .key          (key),
    .audio_sample (audio_sample),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

  always #10 CLK_50M = ~CLK_50M;  // 50 MHz

  // ====================================================================
  // Helpers
  // ====================================================================
  // Half periods as listed for the board, 011 and 100 out of order
  function automatic int expected_half_period(input logic [2:0] code);
    case (code)
      3'b000: return 47801;
      3'b001: return 42589;
      3'b010: return 37936;
      3'b100: return 35816;
      3'b011: return 31928;
      3'b101: return 28409;
      3'b110: return 25329;
      3'b111: return 23900;
      default: return 0;
    endcase
  endfunction

  task automatic drive_sw(input logic [3:0] value);
    @(posedge CLK_50M);
    sw <= value;
    @(negedge CLK_50M);  // Sample side of the cycle
  endtask

  task automatic drive_keys(input logic [2:0] value);
    @(posedge CLK_50M);
    key <= value;
    @(negedge CLK_50M);
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) @(negedge CLK_50M);
  endtask

  // Digits back to a count through the glyph table
  task automatic read_display(output logic [15:0] value);
    seg_t        digits [6];
    logic [23:0] full;
    int          nib;
    digits[0] = hex0;
    digits[1] = hex1;
    digits[2] = hex2;
    digits[3] = hex3;
    digits[4] = hex4;
    digits[5] = hex5;
    full = '0;
    for (int d = 0; d < 6; d++)
    begin
      nib = -1;
      for (int g = 0; g < 16; g++)
        if (digits[d] == HEX_SEGMENTS[g]) nib = g;
      if (nib < 0)
      begin
        $display("Display digit %0d shows a pattern that is no hex glyph: %b", d, digits[d]);
        error_count++;
      end
      else
        full[4*d +: 4] = nib[3:0];
    end
    if (full[23:16] != 8'h00)
    begin
      $display("The two upper display digits do not show 0, they read %h", full[23:16]);
      error_count++;
    end
    value = full[15:0];
  endtask

  // Counts cycles until audio_sample moves
  task automatic wait_sample_change(output int cycles, output bit ok);
    sample_t prev;
    prev   = audio_sample;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < TONE_WAIT)
    begin
      @(negedge CLK_50M);
      cycles++;
      if (audio_sample !== prev) ok = 1'b1;
    end
  endtask

  task automatic wait_display_change(input logic [15:0] old, output logic [15:0] now,
                                     output bit ok);
    int unsigned n;
    n  = 0;
    ok = 1'b0;
    now = old;
    while (!ok && n < STEP_WAIT)
    begin
      @(negedge CLK_50M);
      n++;
      read_display(now);
      if (now !== old) ok = 1'b1;
    end
  endtask

  task automatic wait_display_value(input logic [15:0] target, output bit ok);
    logic [15:0] now;
    int unsigned n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < STEP_WAIT)
    begin
      @(negedge CLK_50M);
      n++;
      read_display(now);
      if (now === target) ok = 1'b1;
    end
  endtask

  task automatic close_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before)
      $display("[%0t] %s: ok", $time, name);
    else
      $display("[%0t] %s: %0d error(s)", $time, name, error_count - errors_before);
  endtask

  // ====================================================================
  // Tests
  // ====================================================================
  task automatic test_reset_state();
    int          errors_before;
    logic [15:0] shown;
    bit          ok;
    errors_before = error_count;
    @(negedge CLK_50M);  // First cycle out of reset, before any refresh
    if (audio_sample !== SAMPLE_LOW)
    begin
      $display("FAILED reset_state: sample expected %h actual %h", SAMPLE_LOW, audio_sample);
      error_count++;
    end
    read_display(shown);
    if (shown !== 16'h0000)
    begin
      $display("FAILED reset_state: display expected 0000 actual %h", shown);
      error_count++;
    end
    wait_display_value(EXP_DEFAULT, ok);
    if (!ok)
    begin
      read_display(shown);
      $display("FAILED reset_state: display expected %h actual %h", EXP_DEFAULT, shown);
      error_count++;
    end
    close_test("reset_state", errors_before);
  endtask

  task automatic test_note_periods();
    int      errors_before;
    int      order [8];
    int      j;
    int      tmp;
    int      cycles;
    int      exp_cycles;
    bit      ok;
    sample_t prev_level;
    sample_t exp_level;
    errors_before = error_count;
    for (int i = 0; i < 8; i++)
      order[i] = i;
    for (int i = 7; i > 0; i--)  // Shuffle
    begin
      j        = int'($unsigned($random(seed)) % (i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    // Muted on another note, so the first pick restarts the counter
    drive_sw({order[0][2:0] ^ 3'b111, 1'b0});
    for (int i = 0; i < 8; i++)
    begin
      exp_cycles = expected_half_period(order[i][2:0]);
      drive_sw({order[i][2:0], 1'b1});
      wait_sample_change(cycles, ok);  // Partial level after the switch
      prev_level = audio_sample;
      for (int k = 0; k < 2 && ok; k++)
      begin
        exp_level = (prev_level === SAMPLE_HIGH) ? SAMPLE_LOW : SAMPLE_HIGH;
        wait_sample_change(cycles, ok);
        if (ok && cycles != exp_cycles)
        begin
          $display("FAILED note_periods: note %b half period expected %0d actual %0d",
                   order[i][2:0], exp_cycles, cycles);
          error_count++;
        end
        if (ok && audio_sample !== exp_level)
        begin
          $display("FAILED note_periods: note %b sample expected %h actual %h",
                   order[i][2:0], exp_level, audio_sample);
          error_count++;
        end
        prev_level = audio_sample;
      end
      if (!ok)
      begin
        $display("Note %b: audio sample stopped changing, wait timed out", order[i][2:0]);
        error_count++;
      end
    end
    close_test("note_periods", errors_before);
  endtask

  task automatic test_mute();
    int errors_before;
    bit seen_bad;
    errors_before = error_count;
    seen_bad      = 1'b0;
    drive_sw(4'b0000);
    idle_cycles(2);  // Output register catches up
    for (int unsigned n = 0; n < LONGEST_HALF + 10 && !seen_bad; n++)
    begin
      @(negedge CLK_50M);
      if (audio_sample !== SAMPLE_LOW)
      begin
        $display("FAILED mute: sample expected %h actual %h", SAMPLE_LOW, audio_sample);
        error_count++;
        seen_bad = 1'b1;
      end
    end
    close_test("mute", errors_before);
  endtask

  // One step in a direction, then the display must move by one step
  task automatic single_step(input logic [2:0] press, input int delta);
    logic [15:0] old;
    logic [15:0] now;
    logic [15:0] exp_val;
    bit          ok;
    read_display(old);
    drive_keys(press);
    wait_display_change(old, now, ok);
    drive_keys(3'b111);  // Release at once
    if (!ok)
    begin
      $display("Display did not change within %0d cycles of a key press", STEP_WAIT);
      error_count++;
    end
    idle_cycles(SETTLE);
    read_display(now);
    exp_val = old + 16'(delta);
    if (now !== exp_val)
    begin
      $display("FAILED single_steps: display expected %h actual %h", exp_val, now);
      error_count++;
    end
  endtask

  task automatic test_single_steps();
    int errors_before;
    errors_before = error_count;
    single_step(3'b110, EXP_STEP);   // Up
    single_step(3'b101, -EXP_STEP);  // Down
    close_test("single_steps", errors_before);
  endtask

  task automatic test_repeat_clear();
    int          errors_before;
    logic [15:0] old;
    logic [15:0] now;
    logic [15:0] rise;
    bit          ok;
    bit          seen_bad;
    errors_before = error_count;
    seen_bad      = 1'b0;
    read_display(old);
    drive_keys(3'b110);
    idle_cycles(5 * REPEAT_TICKS);
    drive_keys(3'b111);
    idle_cycles(SETTLE);
    read_display(now);
    rise = now - old;
    if ((rise % EXP_STEP) != 0 || rise < 4 * EXP_STEP || rise > 6 * EXP_STEP)
    begin
      $display("FAILED repeat_clear: rise expected 400 to 600 in steps of 100 actual %0d",
               rise);
      error_count++;
    end
    // Clear together with up, clear must win
    drive_keys(3'b010);
    wait_display_value(EXP_DEFAULT, ok);
    if (!ok)
    begin
      read_display(now);
      $display("FAILED repeat_clear: display expected %h actual %h", EXP_DEFAULT, now);
      error_count++;
    end
    for (int unsigned n = 0; n < 3 * REPEAT_TICKS && ok && !seen_bad; n++)
    begin
      @(negedge CLK_50M);
      read_display(now);
      if (now !== EXP_DEFAULT)
      begin
        $display("FAILED repeat_clear: held display expected %h actual %h", EXP_DEFAULT, now);
        error_count++;
        seen_bad = 1'b1;
      end
    end
    drive_keys(3'b111);
    close_test("repeat_clear", errors_before);
  endtask

  // ====================================================================
  // Sequence
  // ====================================================================
  initial
  begin
    CLK_50M     = 1'b0;
    rst_n       = 1'b0;
    sw          = 4'b0000;
    key         = 3'b111;  // Keys idle high
    error_count = 0;
    test_count  = 0;
    seed        = 32'h06a2_dd51;
    repeat (16) @(posedge CLK_50M);
    rst_n <= 1'b1;

    test_reset_state();
    test_note_periods();
    test_mute();
    test_single_steps();
    test_repeat_clear();

    $display("Tests run: %0d, errors: %0d", test_count, error_count);
    if (error_count == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== tone_generator.sv ====
`timescale 1ns/1ns

module tone_generator (
  input  logic                 CLK_50M,
  input  logic                 rst_n,
  input  organ_pkg::note_code_t note,
  input  logic                 enable,
  output organ_pkg::sample_t   audio_sample
);
  import organ_pkg::*;

  half_period_t half_period;  // Selected note
  half_period_t last_count;
  half_period_t cnt;
  note_code_t   note_q;       // Previous note, spots a change
  logic         wave;
  logic         wrap;

  always_comb
  begin
    half_period = NOTE_HALF_PERIOD[note];
    last_count  = half_period - 16'd1;
    wrap        = (cnt == last_count);
  end

  // ====================================================================
  // Half-period counter and square wave
  // ====================================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt    <= '0;
      note_q <= '0;
      wave   <= 1'b0;
    end
    else
    begin
      note_q <= note;
      if (note != note_q)
      begin
        cnt <= '0;  // Restart on a new note
      end
      else if (wrap)
      begin
        cnt  <= '0;
        wave <= ~wave;
      end
      else
      begin
        cnt <= cnt + 16'd1;
      end
    end
  end

  // Gated wave to signed sample
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      audio_sample <= SAMPLE_LOW;
    else
      audio_sample <= (wave && enable) ? SAMPLE_HIGH : SAMPLE_LOW;
  end

endmodule

// ==== vlog.f ====
organ_pkg.sv
tone_generator.sv
speed_keys.sv
sample_rate_control.sv
hex_display.sv
organ_top.sv
organ_asserts.sv
tb_organ.sv
